/* src/axi2wb_pkg.sv */
package axi2wb_pkg;

	//////////////////////////////////////////////////
	// bus widths
	//////////////////////////////////////////////////

	// axi id, byte address and data
	localparam int ID_WIDTH = 6;
	localparam int ADDR_WIDTH = 28;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// byte offset bits, not carried on wishbone
	localparam int ADDR_LSBS = 2;
	localparam int WB_ADDR_WIDTH = ADDR_WIDTH - ADDR_LSBS;

	// b channel response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	//////////////////////////////////////////////////
	// channel payloads
	//////////////////////////////////////////////////

	// aw channel, one per burst
	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [7:0]            len;
	} aw_req_t;

	// w channel, one per beat
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
		logic                  last;
	} w_beat_t;

	// wishbone write request, word addressed
	typedef struct packed {
		logic [WB_ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0]    data;
		logic [STRB_WIDTH-1:0]    sel;
	} wb_req_t;

	// b channel, one per burst
	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		logic [1:0]          resp;
	} b_resp_t;

endpackage

/* src/axi_skid_buffer.sv */
`timescale 1ns/1ps

module axi_skid_buffer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	// upstream side
	input  logic     i_valid,
	output logic     o_ready,
	input  payload_t i_data,
	// downstream side
	output logic     o_valid,
	input  logic     i_ready,
	output payload_t o_data
);

	// holding register, one entry
	payload_t r_data;

	//////////////////////////////////////////////////
	// ready, doubles as the "buffer empty" flag
	//////////////////////////////////////////////////

	// high out of reset
	// drops once an item is parked, rises when it drains
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_ready <= 1'b1;
		end
		else if (i_valid && o_ready && !i_ready)
		begin
			// downstream stalled, park the incoming item
			o_ready <= 1'b0;
		end
		else if (i_ready)
		begin
			o_ready <= 1'b1;
		end
	end

	// capture whenever empty
	// only kept when ready falls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
		begin
			r_data <= i_data;
		end
	end

	//////////////////////////////////////////////////
	// output side
	//////////////////////////////////////////////////

	// empty: pass straight through
	// full: present the parked item first
	assign o_valid = i_valid || !o_ready;
	assign o_data = o_ready ? i_data : r_data;

endmodule

/* src/burst_decode.sv */
`timescale 1ns/1ps

module burst_decode (
	input  logic                                S_AXI_ACLK,
	input  logic                                S_AXI_ARESETN,
	// aw from skid buffer
	input  logic                                i_aw_valid,
	output logic                                o_aw_ready,
	input  axi2wb_pkg::aw_req_t                 i_aw,
	// w from skid buffer
	input  logic                                i_w_valid,
	output logic                                o_w_ready,
	input  axi2wb_pkg::w_beat_t                 i_w,
	// issue stage handshake
	input  logic                                i_beat_ready,
	input  logic                                i_b_taken,
	output logic                                o_beat_stb,
	output logic                                o_beat_last,
	output axi2wb_pkg::wb_req_t                 o_beat,
	// id of the active burst
	output logic [axi2wb_pkg::ID_WIDTH-1:0]     o_id
);

	import axi2wb_pkg::*;

	// active burst state
	logic                     r_active;
	logic                     r_all_sent;
	logic [WB_ADDR_WIDTH-1:0] r_addr;
	logic [7:0]               r_count;
	logic [ID_WIDTH-1:0]      r_id;

	logic aw_take;

	//////////////////////////////////////////////////
	// handshakes
	//////////////////////////////////////////////////

	// one burst at a time, idle until b is taken
	assign o_aw_ready = !r_active;
	assign aw_take = i_aw_valid && o_aw_ready;

	// beats only while the burst still owes data
	assign o_w_ready = r_active && !r_all_sent && i_beat_ready;
	assign o_beat_stb = i_w_valid && o_w_ready;

	// last from own count, wlast ignored
	assign o_beat_last = (r_count == 8'd0);

	always_comb
	begin
		o_beat.addr = r_addr;
		o_beat.data = i_w.data;
		o_beat.sel = i_w.strb;
	end

	assign o_id = r_id;

	//////////////////////////////////////////////////
	// control state
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_active <= 1'b0;
			r_all_sent <= 1'b0;
		end
		else if (aw_take)
		begin
			r_active <= 1'b1;
			r_all_sent <= 1'b0;
		end
		else if (i_b_taken)
		begin
			// response accepted, free for next aw
			r_active <= 1'b0;
			r_all_sent <= 1'b0;
		end
		else if (o_beat_stb && o_beat_last)
		begin
			r_all_sent <= 1'b1;
		end
	end

	// address and count, incr only
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_take)
		begin
			r_addr <= i_aw.addr[ADDR_WIDTH-1:ADDR_LSBS];
			r_count <= i_aw.len;
			r_id <= i_aw.id;
		end
		else if (o_beat_stb)
		begin
			// one word per beat
			r_addr <= r_addr + 1'b1;
			r_count <= r_count - 8'd1;
		end
	end

endmodule

/* src/wb_write_issue.sv */
`timescale 1ns/1ps

module wb_write_issue #(
	parameter bit OPT_SWAP_ENDIANNESS = 1'b1
) (
	input  logic                S_AXI_ACLK,
	input  logic                S_AXI_ARESETN,
	// beats from the decoder
	input  logic                i_beat_stb,
	input  logic                i_beat_last,
	input  axi2wb_pkg::wb_req_t i_beat,
	output logic                o_beat_ready,
	// wishbone master side
	output logic                o_wb_cyc,
	output logic                o_wb_stb,
	output axi2wb_pkg::wb_req_t o_wb_req,
	input  logic                i_wb_stall,
	input  logic                i_wb_ack,
	input  logic                i_wb_err,
	// burst completion
	output logic                o_done_stb,
	output logic                o_done_err
);

	import axi2wb_pkg::*;

	wb_req_t    swapped;
	logic [8:0] r_pending;
	logic       r_last_issued;
	logic       r_err;
	logic       err_now;
	logic       err_any;
	logic       issue;
	logic       ack_dec;
	logic       final_ack;
	logic       done_next;

	//////////////////////////////////////////////////
	// byte lane swap
	//////////////////////////////////////////////////

	always_comb
	begin
		swapped = i_beat;
		if (OPT_SWAP_ENDIANNESS)
		begin
			for (int k = 0; k < STRB_WIDTH; k++)
			begin
				swapped.data[k*8 +: 8] = i_beat.data[(STRB_WIDTH-1-k)*8 +: 8];
				swapped.sel[k] = i_beat.sel[STRB_WIDTH-1-k];
			end
		end
	end

	//////////////////////////////////////////////////
	// strobes for this cycle
	//////////////////////////////////////////////////

	// held request blocks the decoder
	assign o_beat_ready = !(o_wb_stb && i_wb_stall);

	assign err_now = o_wb_cyc && i_wb_err;
	assign err_any = r_err || err_now;
	// beats after an error are swallowed
	assign issue = i_beat_stb && !err_any;
	assign ack_dec = o_wb_cyc && i_wb_ack;
	assign final_ack = ack_dec && r_last_issued && (r_pending == 9'd1);

	// normal end, error after the last beat, or last beat after an error
	assign done_next = (final_ack && !err_any)
		|| (err_now && r_last_issued)
		|| (i_beat_stb && i_beat_last && err_any);

	//////////////////////////////////////////////////
	// wishbone cycle
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || err_now)
		begin
			// error drops the whole cycle
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else
		begin
			if (!o_wb_stb || !i_wb_stall)
			begin
				o_wb_stb <= issue;
			end
			if (issue)
			begin
				o_wb_cyc <= 1'b1;
			end
			else if (final_ack)
			begin
				o_wb_cyc <= 1'b0;
			end
		end
	end

	// issue only happens when not stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (issue)
		begin
			o_wb_req <= swapped;
		end
	end

	//////////////////////////////////////////////////
	// ack counting and completion
	//////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || err_now || done_next)
		begin
			r_pending <= 9'd0;
		end
		else
		begin
			case ({issue, ack_dec})
			2'b10: r_pending <= r_pending + 9'd1;
			2'b01: r_pending <= r_pending - 9'd1;
			default: r_pending <= r_pending;
			endcase
		end
	end

	// error and last flags live until completion
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || done_next)
		begin
			r_err <= 1'b0;
			r_last_issued <= 1'b0;
		end
		else
		begin
			if (err_now)
			begin
				r_err <= 1'b1;
			end
			if (i_beat_stb && i_beat_last)
			begin
				r_last_issued <= 1'b1;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_done_stb <= 1'b0;
		end
		else
		begin
			o_done_stb <= done_next;
		end
	end

	// only looked at with o_done_stb
	always_ff @(posedge S_AXI_ACLK)
	begin
		o_done_err <= err_any;
	end

endmodule

/* src/bresp_return.sv */
`timescale 1ns/1ps

module bresp_return (
	input  logic                            S_AXI_ACLK,
	input  logic                            S_AXI_ARESETN,
	// completion from the issue stage
	input  logic                            i_done_stb,
	input  logic                            i_done_err,
	input  logic [axi2wb_pkg::ID_WIDTH-1:0] i_id,
	// axi b channel
	output logic                            o_bvalid,
	input  logic                            i_bready,
	output axi2wb_pkg::b_resp_t             o_b,
	// tells the decoder the burst is closed
	output logic                            o_b_taken
);

	import axi2wb_pkg::*;

	//////////////////////////////////////////////////
	// response register
	//////////////////////////////////////////////////

	// valid, held until the master takes it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_bvalid <= 1'b0;
		end
		else if (i_done_stb)
		begin
			o_bvalid <= 1'b1;
		end
		else if (i_bready)
		begin
			o_bvalid <= 1'b0;
		end
	end

	// id and code latched with the strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_done_stb)
		begin
			o_b.id <= i_id;
			o_b.resp <= i_done_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

	// handshake strobe
	assign o_b_taken = o_bvalid && i_bready;

endmodule

/* src/axi2wb_write_bridge.sv */
`timescale 1ns/1ps

module axi2wb_write_bridge #(
	parameter bit OPT_SWAP_ENDIANNESS = 1'b1
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// aw channel
	input  logic                                 i_axi_awvalid,
	output logic                                 o_axi_awready,
	input  logic [axi2wb_pkg::ID_WIDTH-1:0]      i_axi_awid,
	input  logic [axi2wb_pkg::ADDR_WIDTH-1:0]    i_axi_awaddr,
	input  logic [7:0]                           i_axi_awlen,
	// w channel
	input  logic                                 i_axi_wvalid,
	output logic                                 o_axi_wready,
	input  logic [axi2wb_pkg::DATA_WIDTH-1:0]    i_axi_wdata,
	input  logic [axi2wb_pkg::STRB_WIDTH-1:0]    i_axi_wstrb,
	input  logic                                 i_axi_wlast,
	// b channel
	output logic                                 o_axi_bvalid,
	input  logic                                 i_axi_bready,
	output logic [axi2wb_pkg::ID_WIDTH-1:0]      o_axi_bid,
	output logic [1:0]                           o_axi_bresp,
	// wishbone
	output logic                                 o_wb_cyc,
	output logic                                 o_wb_stb,
	output logic [axi2wb_pkg::WB_ADDR_WIDTH-1:0] o_wb_addr,
	output logic [axi2wb_pkg::DATA_WIDTH-1:0]    o_wb_data,
	output logic [axi2wb_pkg::STRB_WIDTH-1:0]    o_wb_sel,
	input  logic                                 i_wb_stall,
	input  logic                                 i_wb_ack,
	input  logic                                 i_wb_err
);

	import axi2wb_pkg::*;

	aw_req_t             aw_in, aw_skid;
	w_beat_t             w_in, w_skid;
	logic                aw_skid_valid, aw_skid_ready;
	logic                w_skid_valid, w_skid_ready;
	logic                beat_stb, beat_last, beat_ready;
	wb_req_t             beat, wb_req;
	logic                done_stb, done_err, b_taken;
	logic [ID_WIDTH-1:0] burst_id;
	b_resp_t             b_out;

	// port packing
	assign aw_in = '{id: i_axi_awid, addr: i_axi_awaddr, len: i_axi_awlen};
	assign w_in = '{data: i_axi_wdata, strb: i_axi_wstrb, last: i_axi_wlast};

	//////////////////////////////////////////////////
	// input skid buffers
	//////////////////////////////////////////////////

	axi_skid_buffer #(.payload_t(aw_req_t)) i_aw_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_axi_awvalid), .o_ready(o_axi_awready), .i_data(aw_in),
		.o_valid(aw_skid_valid), .i_ready(aw_skid_ready), .o_data(aw_skid)
	);

	axi_skid_buffer #(.payload_t(w_beat_t)) i_w_skid (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_valid(i_axi_wvalid), .o_ready(o_axi_wready), .i_data(w_in),
		.o_valid(w_skid_valid), .i_ready(w_skid_ready), .o_data(w_skid)
	);

	//////////////////////////////////////////////////
	// decode, issue, respond
	//////////////////////////////////////////////////

	burst_decode i_burst_decode (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_aw_valid(aw_skid_valid), .o_aw_ready(aw_skid_ready), .i_aw(aw_skid),
		.i_w_valid(w_skid_valid), .o_w_ready(w_skid_ready), .i_w(w_skid),
		.i_beat_ready(beat_ready), .i_b_taken(b_taken),
		.o_beat_stb(beat_stb), .o_beat_last(beat_last), .o_beat(beat),
		.o_id(burst_id)
	);

	wb_write_issue #(.OPT_SWAP_ENDIANNESS(OPT_SWAP_ENDIANNESS)) i_wb_write_issue (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_beat_stb(beat_stb), .i_beat_last(beat_last), .i_beat(beat),
		.o_beat_ready(beat_ready),
		.o_wb_cyc, .o_wb_stb, .o_wb_req(wb_req),
		.i_wb_stall, .i_wb_ack, .i_wb_err,
		.o_done_stb(done_stb), .o_done_err(done_err)
	);

	bresp_return i_bresp_return (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_done_stb(done_stb), .i_done_err(done_err), .i_id(burst_id),
		.o_bvalid(o_axi_bvalid), .i_bready(i_axi_bready),
		.o_b(b_out), .o_b_taken(b_taken)
	);

	// port unpacking
	assign o_wb_addr = wb_req.addr;
	assign o_wb_data = wb_req.data;
	assign o_wb_sel = wb_req.sel;
	assign o_axi_bid = b_out.id;
	assign o_axi_bresp = b_out.resp;

endmodule

/* test/wb_slave_model.sv */
`timescale 1ns/1ps

module wb_slave_model (
	input  logic        S_AXI_ACLK,
	// wishbone from the bridge
	input  logic        i_cyc,
	input  logic        i_stb,
	// random word from the testbench, new every rising edge
	input  logic [31:0] i_rnd,
	// error request for the current cycle
	input  logic        i_err_en,
	input  logic [8:0]  i_err_beat,
	// responses, changed on the falling edge
	output logic        o_stall,
	output logic        o_ack,
	output logic        o_err
);

	// edge counter and outstanding requests
	int unsigned cycle;
	int unsigned n_acc;
	int unsigned due_q[$];
	int unsigned idx_q[$];

	initial
	begin
		o_stall = 1'b0;
		o_ack = 1'b0;
		o_err = 1'b0;
		cycle = 0;
		n_acc = 0;
	end

	//////////////////////////////////////////////////
	// request acceptance
	//////////////////////////////////////////////////

	// a request counts when stb is seen without stall
	always @(posedge S_AXI_ACLK)
	begin
		cycle = cycle + 1;
		if (i_cyc && i_stb && !o_stall)
		begin
			// answer after 0 to 2 extra cycles
			due_q.push_back(cycle + int'(i_rnd[5:4]) % 3);
			idx_q.push_back(n_acc);
			n_acc = n_acc + 1;
		end
	end

	//////////////////////////////////////////////////
	// responses, one per cycle, in order
	//////////////////////////////////////////////////

	always @(negedge S_AXI_ACLK)
	begin
		o_ack = 1'b0;
		o_err = 1'b0;
		if (!i_cyc)
		begin
			// cycle over, anything still owed is abandoned
			due_q.delete();
			idx_q.delete();
			n_acc = 0;
		end
		else if (due_q.size() > 0 && due_q[0] <= cycle)
		begin
			// chosen request gets err instead of ack
			if (i_err_en && idx_q[0] == i_err_beat)
			begin
				o_err = 1'b1;
			end
			else
			begin
				o_ack = 1'b1;
			end
			void'(due_q.pop_front());
			void'(idx_q.pop_front());
		end
		// stall roughly one cycle in four
		o_stall = (i_rnd[1:0] == 2'b00);
	end

endmodule

/* test/tb_axi2wb_write.sv */
`timescale 1ns/1ps

module tb_axi2wb_write;

	import axi2wb_pkg::*;

	localparam int N_BURSTS = 40;
	localparam int TIMEOUT = 2000;
	localparam logic [31:0] SEED = 32'h02c8ba92;

	// one entry per burst, for the wishbone side
	typedef struct packed {
		logic       err_en;
		logic [8:0] err_beat;
		logic [8:0] beats;
	} burst_t;

	logic                     S_AXI_ACLK;
	logic                     S_AXI_ARESETN;
	logic                     i_axi_awvalid;
	logic                     o_axi_awready;
	logic [ID_WIDTH-1:0]      i_axi_awid;
	logic [ADDR_WIDTH-1:0]    i_axi_awaddr;
	logic [7:0]               i_axi_awlen;
	logic                     i_axi_wvalid;
	logic                     o_axi_wready;
	logic [DATA_WIDTH-1:0]    i_axi_wdata;
	logic [STRB_WIDTH-1:0]    i_axi_wstrb;
	logic                     i_axi_wlast;
	logic                     o_axi_bvalid;
	logic                     i_axi_bready;
	logic [ID_WIDTH-1:0]      o_axi_bid;
	logic [1:0]               o_axi_bresp;
	logic                     o_wb_cyc;
	logic                     o_wb_stb;
	logic [WB_ADDR_WIDTH-1:0] o_wb_addr;
	logic [DATA_WIDTH-1:0]    o_wb_data;
	logic [STRB_WIDTH-1:0]    o_wb_sel;
	logic                     i_wb_stall;
	logic                     i_wb_ack;
	logic                     i_wb_err;

	// stimulus and slave random streams
	logic [31:0] rng;
	logic [31:0] slave_rnd;
	logic        err_en;
	logic [8:0]  err_beat;

	// reference model
	wb_req_t     exp_wb_q[$];
	b_resp_t     exp_b_q[$];
	burst_t      burst_q[$];
	int unsigned b_count;

	// monitor state carried between edges
	logic        cyc_prev;
	logic        err_prev;
	logic        hold_prev;
	logic        b_wait;
	wb_req_t     held_req;
	b_resp_t     b_held;
	int unsigned beats_seen;
	int unsigned acks_seen;

	axi2wb_write_bridge #(.OPT_SWAP_ENDIANNESS(1'b1)) i_axi2wb_write_bridge (.*);

	wb_slave_model i_wb_slave (
		.S_AXI_ACLK,
		.i_cyc(o_wb_cyc), .i_stb(o_wb_stb), .i_rnd(slave_rnd),
		.i_err_en(err_en), .i_err_beat(err_beat),
		.o_stall(i_wb_stall), .o_ack(i_wb_ack), .o_err(i_wb_err)
	);

	always #4 S_AXI_ACLK = ~S_AXI_ACLK;

	always @(posedge S_AXI_ACLK)
	begin
		slave_rnd <= xorshift32(slave_rnd);
	end

	// bready low about a third of the time, runs of several cycles happen
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			i_axi_bready = (slave_rnd[12:10] > 3'd2);
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// waits out one valid/ready transfer, returns on the next falling edge
	task automatic await_accept(input bit is_w);
		int n;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
			if (n > TIMEOUT)
				abort_run(is_w ? "W beat was never accepted" : "AW request was never accepted");
		end
		while (!(is_w ? o_axi_wready : o_axi_awready));
		@(negedge S_AXI_ACLK);
	endtask

	//////////////////////////////////////////////////
	// one burst: expectations first, then AW and W
	//////////////////////////////////////////////////

	task automatic send_burst(input int idx);
		logic [31:0]           r;
		logic [7:0]            len;
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] wd[256];
		logic [STRB_WIDTH-1:0] ws[256];
		burst_t                b;
		wb_req_t               e;
		// first burst is a single beat
		r = next_rand();
		len = (idx == 0) ? 8'd0 : 8'(r % 16);
		id = r[ID_WIDTH+7:8];
		r = next_rand();
		addr = r[ADDR_WIDTH-1:0];
		r = next_rand();
		// every fourth burst takes an error, the one after it is clean
		b.err_en = (idx % 4 == 3);
		b.err_beat = 9'(r % (len + 1));
		b.beats = 9'(len) + 9'd1;
		burst_q.push_back(b);
		exp_b_q.push_back('{id: id, resp: b.err_en ? RESP_SLVERR : RESP_OKAY});
		for (int k = 0; k <= len; k++)
		begin
			wd[k] = next_rand();
			r = next_rand();
			ws[k] = r[STRB_WIDTH-1:0];
			// word address steps by one, byte lanes reversed
			e.addr = addr[ADDR_WIDTH-1:ADDR_LSBS] + WB_ADDR_WIDTH'(k);
			e.data = {<<8{wd[k]}};
			e.sel = {<<{ws[k]}};
			exp_wb_q.push_back(e);
		end
		i_axi_awvalid = 1'b1;
		i_axi_awid = id;
		i_axi_awaddr = addr;
		i_axi_awlen = len;
		await_accept(1'b0);
		i_axi_awvalid = 1'b0;
		for (int k = 0; k <= len; k++)
		begin
			r = next_rand();
			if (r[1:0] == 2'b00)
			begin
				// idle cycle between beats
				@(negedge S_AXI_ACLK);
			end
			i_axi_wvalid = 1'b1;
			i_axi_wdata = wd[k];
			i_axi_wstrb = ws[k];
			i_axi_wlast = (k == len);
			await_accept(1'b1);
			i_axi_wvalid = 1'b0;
		end
	endtask

	//////////////////////////////////////////////////
	// wishbone and b channel checks
	//////////////////////////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		wb_req_t got;
		wb_req_t exp_req;
		b_resp_t exp_b;
		burst_t  head;
		got = '{addr: o_wb_addr, data: o_wb_data, sel: o_wb_sel};
		if (!S_AXI_ARESETN)
		begin
			cyc_prev = 1'b0;
			err_prev = 1'b0;
			hold_prev = 1'b0;
			b_wait = 1'b0;
			beats_seen = 0;
			acks_seen = 0;
		end
		else
		begin
			if (err_prev)
				assert (!o_wb_cyc) else abort_run("o_wb_cyc still high on the edge after an error");
			// stalled request must not move
			if (hold_prev)
			begin
				check_hex("o_wb_stb", o_wb_stb, 1);
				check_hex("o_wb_addr", o_wb_addr, held_req.addr);
				check_hex("o_wb_data", o_wb_data, held_req.data);
				check_hex("o_wb_sel", o_wb_sel, held_req.sel);
			end
			if (o_wb_stb)
				assert (o_wb_cyc) else abort_run("o_wb_stb is high outside a bus cycle");
			if (o_wb_cyc && o_wb_stb && !i_wb_stall)
			begin
				assert (exp_wb_q.size() > 0) else abort_run("unexpected Wishbone request");
				exp_req = exp_wb_q.pop_front();
				check_hex("o_wb_addr", o_wb_addr, exp_req.addr);
				check_hex("o_wb_data", o_wb_data, exp_req.data);
				check_hex("o_wb_sel", o_wb_sel, exp_req.sel);
				beats_seen++;
			end
			if (o_wb_cyc && i_wb_ack)
				acks_seen++;
			// end of a bus cycle closes one burst
			if (cyc_prev && !o_wb_cyc)
			begin
				assert (burst_q.size() > 0) else abort_run("bus cycle ended with no burst pending");
				head = burst_q.pop_front();
				assert (beats_seen <= head.beats) else abort_run("more requests than beats in burst");
				if (err_prev)
				begin
					// beats after the error never reach the bus
					repeat (int'(head.beats) - int'(beats_seen)) void'(exp_wb_q.pop_front());
				end
				else
				begin
					check_hex("beats in cycle", beats_seen, head.beats);
					check_hex("acks in cycle", acks_seen, head.beats);
				end
				beats_seen = 0;
				acks_seen = 0;
			end
			// b must hold under back-pressure
			if (b_wait)
			begin
				check_hex("o_axi_bvalid", o_axi_bvalid, 1);
				check_hex("o_axi_bid", o_axi_bid, b_held.id);
				check_hex("o_axi_bresp", o_axi_bresp, b_held.resp);
			end
			if (o_axi_bvalid)
				assert (!o_wb_cyc) else abort_run("bus cycle started while a B response waits");
			if (o_axi_bvalid && i_axi_bready)
			begin
				assert (exp_b_q.size() > 0) else abort_run("unexpected B response");
				exp_b = exp_b_q.pop_front();
				check_hex("o_axi_bid", o_axi_bid, exp_b.id);
				check_hex("o_axi_bresp", o_axi_bresp, exp_b.resp);
				b_count++;
			end
			b_wait = o_axi_bvalid && !i_axi_bready;
			b_held = '{id: o_axi_bid, resp: o_axi_bresp};
			hold_prev = o_wb_cyc && o_wb_stb && i_wb_stall && !i_wb_err;
			held_req = got;
			err_prev = o_wb_cyc && i_wb_err;
			cyc_prev = o_wb_cyc;
		end
		// slave sees the error choice of the burst at the head
		err_en <= (burst_q.size() > 0) ? burst_q[0].err_en : 1'b0;
		err_beat <= (burst_q.size() > 0) ? burst_q[0].err_beat : 9'd0;
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int n;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		i_axi_awvalid = 1'b0;
		i_axi_awid = '0;
		i_axi_awaddr = '0;
		i_axi_awlen = '0;
		i_axi_wvalid = 1'b0;
		i_axi_wdata = '0;
		i_axi_wstrb = '0;
		i_axi_wlast = 1'b0;
		i_axi_bready = 1'b0;
		rng = SEED;
		slave_rnd = {SEED[15:0], SEED[31:16]};
		err_en = 1'b0;
		err_beat = '0;
		b_count = 0;
		repeat (8) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		// quiet bus out of reset
		check_hex("o_wb_cyc", o_wb_cyc, 0);
		check_hex("o_wb_stb", o_wb_stb, 0);
		check_hex("o_axi_bvalid", o_axi_bvalid, 0);
		for (int i = 0; i < N_BURSTS; i++)
		begin
			send_burst(i);
		end
		n = 0;
		while (b_count < N_BURSTS)
		begin
			@(posedge S_AXI_ACLK);
			n++;
			if (n > TIMEOUT)
				abort_run("not every burst got its B response");
		end
		assert (exp_wb_q.size() == 0) else abort_run("expected Wishbone requests never appeared");
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* verilog.f */
src/axi2wb_pkg.sv
src/axi_skid_buffer.sv
src/burst_decode.sv
src/wb_write_issue.sv
src/bresp_return.sv
src/axi2wb_write_bridge.sv
test/wb_slave_model.sv
test/tb_axi2wb_write.sv

/* Bender.yml */
package:
  name: axi2wb_write_bridge

sources:
  # design
  - files:
      - src/axi2wb_pkg.sv
      - src/axi_skid_buffer.sv
      - src/burst_decode.sv
      - src/wb_write_issue.sv
      - src/bresp_return.sv
      - src/axi2wb_write_bridge.sv

  # simulation only
  - target: test
    files:
      - test/wb_slave_model.sv
      - test/tb_axi2wb_write.sv
